/* cart_pkg.sv */
// Cartridge loader shared definitions
// Download kinds, host bus widths, header title layout, the flash marker
// and the per-title quirk table used by the loader blocks

package cart_pkg;

	// ========================================================================
	// Download classification
	// ========================================================================

	// Kind of the running download, decoded from the host index
	typedef enum logic [1:0] {
		DL_NONE = 2'd0, // No download in progress
		DL_BIOS = 2'd1, // Index zero
		DL_CART = 2'd2, // Any index that is neither zero nor all ones
		DL_CODE = 2'd3  // Index all ones, cheat codes
	} dl_kind_t;

	// ========================================================================
	// Host download bus
	// ========================================================================

	localparam int ADDR_W      = 27; // Byte address
	localparam int DATA_W      = 16; // One halfword per write
	localparam int INDEX_W     = 8;
	localparam int BIOS_ADDR_W = 12; // 16 KB BIOS as 32-bit words

	localparam int CART_TYPE_LSB = 6; // Cart type sits in index bits 7:6

	// ========================================================================
	// Cartridge header
	// ========================================================================

	localparam int TITLE_LINE  = 'hA; // 16-byte line A, title at A0..AB
	localparam int TITLE_BYTES = 12;

	// First character in the top byte
	typedef logic [8*TITLE_BYTES-1:0] title_t;

	// 1M flash save type marker somewhere in the image
	localparam logic [71:0] FLASH_MARKER = "FLASH1M_V";

	// Quirk table
	// Titles are zero padded on the right like the header itself
	localparam int QUIRK_COUNT = 8;

	localparam title_t quirk_title [QUIRK_COUNT] = '{
		{"ROCKY BOXING"},              // Rocky, US release
		{"ROCKY", 56'h0},              // Rocky, EU release
		{"DBZ LGCYGOKU"},              // Legacy of Goku, US
		{"DRAGONBALL Z"},              // Legacy of Goku, EU
		{"TOPGUN CZ", 24'h0},
		{"BOMBER MAN", 16'h0},         // Classic NES series from here on
		{"CASTLEVANIA", 8'h0},
		{"ZELDA 1", 40'h0}
	};

	// Bit i set when entry i also needs the memory remap
	localparam logic [QUIRK_COUNT-1:0] quirk_remap = 8'b1110_0000;

endpackage

/* bios_word_packer.sv */
// BIOS word packer
// Joins low and high halfwords of the BIOS download into 32-bit word
// writes for the BIOS memory

`timescale 1ns/1ps

module bios_word_packer (
	input  logic                             clk_sys,
	input  logic                             reset,
	input  logic                             bios_kind,   // BIOS stream active
	input  logic [cart_pkg::ADDR_W-1:0]      dl_addr,
	input  logic [cart_pkg::DATA_W-1:0]      dl_data,
	input  logic                             dl_wr,
	output logic                             bios_wr,     // One-cycle word write
	output logic [cart_pkg::BIOS_ADDR_W-1:0] bios_addr,
	output logic [31:0]                      bios_data
);

	logic bios_hw_wr;

	assign bios_hw_wr = bios_kind & dl_wr;

	// Word completes on the high halfword
	always_ff @(posedge clk_sys) begin
		if (reset)
			bios_wr <= 1'b0;
		else
			bios_wr <= bios_hw_wr & dl_addr[1];
	end

	always_ff @(posedge clk_sys) begin
		if (bios_hw_wr) begin
			if (!dl_addr[1]) begin
				bios_data[15:0] <= dl_data;  // Low half waits for its partner
			end else begin
				bios_data[31:16] <= dl_data;
				bios_addr        <= dl_addr[2 +: cart_pkg::BIOS_ADDR_W];  // Byte to word
			end
		end
	end

	// Host sends halfwords in order, so word writes are spaced out
	a_bios_wr_single: assert property (@(posedge clk_sys) disable iff (reset)
		bios_wr |=> !bios_wr);

endmodule

/* flash_sig_scanner.sv */
// Flash marker scanner
// Looks for the FLASH1M_V marker anywhere in the cartridge image and
// flags a 1M flash save type for the whole cart

`timescale 1ns/1ps

module flash_sig_scanner (
	input  logic                        clk_sys,
	input  logic                        reset,
	input  logic                        cart_kind,
	input  logic                        cart_start,  // First cycle of a cart stream
	input  logic [cart_pkg::DATA_W-1:0] dl_data,
	input  logic                        dl_wr,
	output logic                        flash_1m
);

	logic [63:0] window;     // Last eight bytes, newest in the low byte
	logic        cart_wr;
	logic        hit_odd;    // Marker ends on the low byte of this halfword
	logic        hit_even;   // Marker ends on the high byte

	assign cart_wr = cart_kind & dl_wr;

	// Low byte comes first in the stream
	assign hit_odd  = ({window, dl_data[7:0]} == cart_pkg::FLASH_MARKER);
	assign hit_even = ({window[55:0], dl_data[7:0], dl_data[15:8]} == cart_pkg::FLASH_MARKER);

	always_ff @(posedge clk_sys) begin
		if (cart_start)
			window <= '0;  // No match across images
		else if (cart_wr)
			window <= {window[47:0], dl_data[7:0], dl_data[15:8]};
	end

	// Sticky until the next image
	always_ff @(posedge clk_sys) begin
		if (reset)
			flash_1m <= 1'b0;
		else if (cart_start)
			flash_1m <= 1'b0;
		else if (cart_wr && (hit_odd || hit_even))
			flash_1m <= 1'b1;
	end

endmodule

/* cart_quirk_detect.sv */
// Cartridge title quirk detector
// Captures the 12-byte game title from the header and checks it against
// the quirk table; a match disables SRAM/flash and may enable the remap

`timescale 1ns/1ps

module cart_quirk_detect (
	input  logic                        clk_sys,
	input  logic                        reset,
	input  logic                        cart_kind,
	input  logic                        cart_start,
	input  logic [cart_pkg::ADDR_W-1:0] dl_addr,
	input  logic [cart_pkg::DATA_W-1:0] dl_data,
	input  logic                        dl_wr,
	output logic                        sram_quirk,   // Backup memory disabled
	output logic                        remap_quirk   // Classic NES series mapping
);

	cart_pkg::title_t title;       // Big-endian by character
	logic             title_wr;    // Cart write inside the title line
	logic [3:0]       line_off;    // Byte offset within the line
	logic [6:0]       slot_lsb;    // Bit position of the halfword in title
	logic             hit;
	logic             hit_remap;

	// ========================================================================
	// Title capture
	// ========================================================================

	assign line_off = dl_addr[3:0];
	assign title_wr = cart_kind & dl_wr & (dl_addr[cart_pkg::ADDR_W-1:4] == cart_pkg::TITLE_LINE);

	// Offset 0 lands in the top two bytes
	assign slot_lsb = {4'(cart_pkg::TITLE_BYTES - 2) - line_off, 3'd0};

	always_ff @(posedge clk_sys) begin
		if (title_wr && line_off < 4'(cart_pkg::TITLE_BYTES))
			title[slot_lsb +: 16] <= {dl_data[7:0], dl_data[15:8]};  // Swap to char order
	end

	// ========================================================================
	// Table lookup
	// ========================================================================

	always_comb begin
		hit       = 1'b0;
		hit_remap = 1'b0;
		for (int i = 0; i < cart_pkg::QUIRK_COUNT; i++) begin
			if (title == cart_pkg::quirk_title[i]) begin
				hit       = 1'b1;
				hit_remap = hit_remap | cart_pkg::quirk_remap[i];
			end
		end
	end

	// Decide once the whole title is in, on the write just past it
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			sram_quirk  <= 1'b0;
			remap_quirk <= 1'b0;
		end else if (cart_start) begin
			sram_quirk  <= 1'b0;  // Fresh image
			remap_quirk <= 1'b0;
		end else if (title_wr && line_off == 4'(cart_pkg::TITLE_BYTES)) begin
			if (hit)
				sram_quirk <= 1'b1;
			if (hit_remap)
				remap_quirk <= 1'b1;
		end
	end

	// Every remap title is also an SRAM title in the table
	a_remap_needs_sram: assert property (@(posedge clk_sys) disable iff (reset)
		remap_quirk |-> sram_quirk);

endmodule

/* cart_loader_top.sv */
// Cartridge loader front end
// Sorts host downloads into BIOS, cartridge and code streams, keeps the
// cart type and final image address, and hosts the BIOS packer, the
// flash marker scanner and the title quirk detector

`timescale 1ns/1ps

module cart_loader_top (
	input  logic                             clk_sys,
	input  logic                             reset,
	input  logic                             dl_active,    // Host download running
	input  logic [cart_pkg::INDEX_W-1:0]     dl_index,
	input  logic [cart_pkg::ADDR_W-1:0]      dl_addr,      // Byte address
	input  logic [cart_pkg::DATA_W-1:0]      dl_data,
	input  logic                             dl_wr,        // One-cycle strobe
	output logic                             bios_wr,
	output logic [cart_pkg::BIOS_ADDR_W-1:0] bios_addr,
	output logic [31:0]                      bios_data,
	output logic                             cart_loading,
	output logic [1:0]                       cart_type,
	output logic                             force_turbo,
	output logic                             flash_1m,
	output logic                             sram_quirk,
	output logic                             remap_quirk,
	output logic [cart_pkg::ADDR_W-1:0]      last_addr
);

	cart_pkg::dl_kind_t dl_kind;  // Registered, one cycle behind dl_active
	logic               cart_kind;
	logic               bios_kind;
	logic               cart_kind_d;
	logic               cart_start;

	// ========================================================================
	// Download kind
	// ========================================================================

	always_ff @(posedge clk_sys) begin
		if (reset)
			dl_kind <= cart_pkg::DL_NONE;
		else if (!dl_active)
			dl_kind <= cart_pkg::DL_NONE;
		else if (dl_index == '0)
			dl_kind <= cart_pkg::DL_BIOS;
		else if (&dl_index)
			dl_kind <= cart_pkg::DL_CODE;  // Cheat codes, nothing consumes them here
		else
			dl_kind <= cart_pkg::DL_CART;
	end

	assign bios_kind    = (dl_kind == cart_pkg::DL_BIOS);
	assign cart_kind    = (dl_kind == cart_pkg::DL_CART);
	assign cart_loading = cart_kind;

	// Edge detect on the cart kind
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			cart_kind_d <= 1'b0;
			cart_type   <= 2'd0;
			last_addr   <= '0;
		end else begin
			cart_kind_d <= cart_kind;
			if (cart_start)
				cart_type <= dl_index[cart_pkg::CART_TYPE_LSB +: 2];
			// First idle cycle after the stream, host still shows the final address
			if (cart_kind_d && !cart_kind)
				last_addr <= dl_addr;
		end
	end

	assign cart_start  = cart_kind & ~cart_kind_d;
	assign force_turbo = |cart_type;  // Special carts need the fast CPU

	// ========================================================================
	// Sub-blocks
	// ========================================================================

	bios_word_packer u_bios_packer (
		.clk_sys(clk_sys), .reset(reset), .bios_kind(bios_kind),
		.dl_addr(dl_addr), .dl_data(dl_data), .dl_wr(dl_wr),
		.bios_wr(bios_wr), .bios_addr(bios_addr), .bios_data(bios_data)
	);

	flash_sig_scanner u_flash_scan (
		.clk_sys(clk_sys), .reset(reset), .cart_kind(cart_kind),
		.cart_start(cart_start), .dl_data(dl_data), .dl_wr(dl_wr),
		.flash_1m(flash_1m)
	);

	cart_quirk_detect u_quirks (
		.clk_sys(clk_sys), .reset(reset), .cart_kind(cart_kind),
		.cart_start(cart_start), .dl_addr(dl_addr), .dl_data(dl_data),
		.dl_wr(dl_wr), .sram_quirk(sram_quirk), .remap_quirk(remap_quirk)
	);

	// A cart stream never follows a BIOS stream without an idle gap
	a_no_cart_start_in_bios: assert property (@(posedge clk_sys) disable iff (reset)
		cart_start |-> ($past(dl_kind) != cart_pkg::DL_BIOS));

endmodule

/* cart_checker.sv */
// Cartridge loader checker
// Predicts the BIOS word writes from the observed halfword stream, follows
// the cart loading flag and compares the end-of-record outputs

`timescale 1ns/1ps

module cart_checker (
	input  logic                             clk_sys,
	input  logic                             reset,
	input  logic                             dl_active,
	input  logic [cart_pkg::INDEX_W-1:0]     dl_index,
	input  logic [cart_pkg::ADDR_W-1:0]      dl_addr,
	input  logic [cart_pkg::DATA_W-1:0]      dl_data,
	input  logic                             dl_wr,
	input  logic                             bios_wr,
	input  logic [cart_pkg::BIOS_ADDR_W-1:0] bios_addr,
	input  logic [31:0]                      bios_data,
	input  logic                             cart_loading,
	input  logic [1:0]                       cart_type,
	input  logic                             force_turbo,
	input  logic                             flash_1m,
	input  logic                             sram_quirk,
	input  logic                             remap_quirk,
	input  logic [cart_pkg::ADDR_W-1:0]      last_addr,
	output int                               checks,
	output int                               errors
);

	string                       name = "reset";   // Record in progress
	logic                        s_live = 1'b0;    // Out of reset at the last rising edge
	logic                        s_wr;
	logic                        s_bios;           // Write belongs to a BIOS stream
	logic                        s_cart;           // Host shows a cart stream
	logic [cart_pkg::ADDR_W-1:0] s_addr;
	logic [cart_pkg::DATA_W-1:0] s_data;
	logic [cart_pkg::DATA_W-1:0] low_half;         // Latest low halfword
	logic [1:0]                  exp_type = 2'd0;
	logic [cart_pkg::ADDR_W-1:0] exp_last = '0;
	int                          bios_checks = 0;
	int                          bios_errors = 0;
	int                          load_checks = 0;
	int                          load_errors = 0;
	int                          rec_checks = 0;
	int                          rec_errors = 0;

	assign checks = bios_checks + load_checks + rec_checks;
	assign errors = bios_errors + load_errors + rec_errors;

	function automatic bit mismatch(input string what, input logic [31:0] expv,
		input logic [31:0] actv);
		if (expv !== actv) begin
			$display("Fail %s %s expected %0h actual %0h", name, what, expv, actv);
			return 1'b1;
		end
		return 1'b0;
	endfunction

	// ========================================================================
	// BIOS word prediction
	// ========================================================================

	always @(posedge clk_sys) begin  // Host inputs are stable here
		s_live <= !reset;
		s_wr   <= dl_wr;
		s_bios <= dl_active && (dl_index == '0);
		s_cart <= dl_active && (dl_index != '0) && (dl_index != '1);
		s_addr <= dl_addr;
		s_data <= dl_data;
	end

	// Outputs settled half a cycle ago, word write due one cycle after the high half
	always @(negedge clk_sys) begin
		logic word_due;
		word_due = s_wr && s_bios && s_addr[1];
		if (s_live) begin
			bios_checks++;
			if (mismatch("bios_wr", 32'(word_due), 32'(bios_wr)))
				bios_errors++;
			if (word_due && bios_wr) begin
				bios_checks += 2;
				if (mismatch("bios_addr", 32'(s_addr[2 +: cart_pkg::BIOS_ADDR_W]), 32'(bios_addr)))
					bios_errors++;
				if (mismatch("bios_data", {s_data, low_half}, bios_data))
					bios_errors++;
			end
			if (s_wr && s_bios && !s_addr[1])
				low_half = s_data;  // Waits for its high partner
		end
	end

	// ========================================================================
	// Cart loading flag
	// ========================================================================

	// One cycle behind dl_active of a cart index
	always @(negedge clk_sys) begin
		if (s_live) begin
			load_checks++;
			if (mismatch("cart_loading", 32'(s_cart), 32'(cart_loading)))
				load_errors++;
		end
	end

	// ========================================================================
	// Record results
	// ========================================================================

	task automatic begin_record(input string rec_name);
		name = rec_name;
	endtask

	// Flags packed as flash_1m, sram_quirk, remap_quirk
	task automatic check_record(input logic [cart_pkg::INDEX_W-1:0] index,
		input logic [cart_pkg::ADDR_W-1:0] start, input int count, input logic [2:0] exp_flags);
		int last_off;
		last_off = count - 1;
		if (index != '0 && index != '1) begin  // Only a cart stream updates these
			exp_type = index[cart_pkg::CART_TYPE_LSB +: 2];
			exp_last = start + {last_off[cart_pkg::ADDR_W-2:0], 1'b0};  // Final halfword
		end
		rec_checks += 4;
		if (mismatch("flags", 32'(exp_flags), 32'({flash_1m, sram_quirk, remap_quirk})))
			rec_errors++;
		if (mismatch("cart_type", 32'(exp_type), 32'(cart_type)))
			rec_errors++;
		if (mismatch("force_turbo", 32'(exp_type != 2'd0), 32'(force_turbo)))
			rec_errors++;
		if (mismatch("last_addr", 32'(exp_last), 32'(last_addr)))
			rec_errors++;
	endtask

endmodule

/* tb_cart_loader.sv */
// Cartridge loader testbench
// Replays the download records of the data file into the loader on falling
// edges and reports the checker's totals

`timescale 1ns/1ps

module tb_cart_loader;

	logic                             clk_sys = 1'b0;
	logic                             reset;
	logic                             dl_active;
	logic [cart_pkg::INDEX_W-1:0]     dl_index;
	logic [cart_pkg::ADDR_W-1:0]      dl_addr;
	logic [cart_pkg::DATA_W-1:0]      dl_data;
	logic                             dl_wr;
	logic                             bios_wr;
	logic [cart_pkg::BIOS_ADDR_W-1:0] bios_addr;
	logic [31:0]                      bios_data;
	logic                             cart_loading;
	logic [1:0]                       cart_type;
	logic                             force_turbo;
	logic                             flash_1m;
	logic                             sram_quirk;
	logic                             remap_quirk;
	logic [cart_pkg::ADDR_W-1:0]      last_addr;
	logic [cart_pkg::DATA_W-1:0]      hw [16];         // Halfwords of the current record
	int                               chk_count;
	int                               err_count;
	int                               run_errors = 0;  // Timeouts and file problems
	integer                           seed = 55;

	always #4 clk_sys = ~clk_sys;  // 8 ns

	cart_loader_top uut (.*);

	cart_checker u_chk (.*, .checks(chk_count), .errors(err_count));

	// ========================================================================
	// Host download side
	// ========================================================================

	// One strobe, then an idle gap of 0 to 3 cycles
	task automatic host_write(input logic [cart_pkg::ADDR_W-1:0] addr,
		input logic [cart_pkg::DATA_W-1:0] data);
		int gap;
		gap = $unsigned($random(seed)) % 4;
		dl_addr = addr;
		dl_data = data;
		dl_wr   = 1'b1;
		@(negedge clk_sys);
		dl_wr = 1'b0;  // Address held, last_addr picks it up later
		for (int i = 0; i < gap; i++)
			@(negedge clk_sys);
	endtask

	task automatic run_record(input string name, input logic [cart_pkg::INDEX_W-1:0] index,
		input logic [cart_pkg::ADDR_W-1:0] start, input int count, input logic [2:0] flags);
		int waited;
		u_chk.begin_record(name);
		dl_index  = index;
		dl_active = 1'b1;
		repeat (2) @(negedge clk_sys);  // Kind settles before the first write
		for (int i = 0; i < count; i++)
			host_write(start + {i[cart_pkg::ADDR_W-2:0], 1'b0}, hw[i]);
		repeat (2) @(negedge clk_sys);
		dl_active = 1'b0;
		waited = 0;
		do begin
			@(negedge clk_sys);
			waited++;
		end while (cart_loading && waited < 16);
		if (cart_loading) begin
			$display("Timeout in %s: cart_loading stayed high after the download ended", name);
			run_errors++;
		end
		repeat (2) @(negedge clk_sys);  // last_addr loads after cart_loading falls
		u_chk.check_record(index, start, count, flags);
	endtask

	// ========================================================================
	// Main sequence
	// ========================================================================

	initial begin
		string                        name;
		string                        rest;
		int                           fd;
		int                           n;
		logic [cart_pkg::INDEX_W-1:0] index;
		logic [cart_pkg::ADDR_W-1:0]  start;
		int                           count;
		logic [2:0]                   flags;
		reset     = 1'b1;
		dl_active = 1'b0;
		dl_index  = '0;
		dl_addr   = '0;
		dl_data   = '0;
		dl_wr     = 1'b0;
		repeat (3) @(negedge clk_sys);
		reset = 1'b0;
		fd = $fopen("cart_testdata.txt", "r");
		if (fd == 0) begin
			$display("Could not open cart_testdata.txt");
			run_errors++;
		end
		while (fd != 0 && $fscanf(fd, "%s", name) == 1) begin
			if (name.getc(0) == "#") begin
				n = $fgets(rest, fd);  // Column notes
			end else begin
				n = $fscanf(fd, "%h %h %d", index, start, count);
				for (int i = 0; i < count && i < 16; i++)
					n = $fscanf(fd, "%h", hw[i]);
				n = $fscanf(fd, "%b", flags);
				if (n != 1) begin
					$display("Record %s in cart_testdata.txt is incomplete", name);
					run_errors++;
				end
				run_record(name, index, start, count, flags);
			end
		end
		if (fd != 0)
			$fclose(fd);
		$display("Checks: %0d, mismatches: %0d, other errors: %0d", chk_count, err_count,
			run_errors);
		if (err_count == 0 && run_errors == 0)
			$display("NO ERRORS");
		else
			$display("ERRORS FOUND");
		$finish;
	end

endmodule

/* cart_testdata.txt */
# name index(hex) start(hex) count halfwords(hex)... flags(bin: flash_1m sram_quirk remap_quirk)
# flags are the outputs expected once the record is over
bios_pairs    00 0010 5 1111 2222 3333 4444 5555 000
flash_even    41 0000 6 0000 4C46 5341 3148 5F4D 0056 100
flash_odd     82 0200 7 1234 4600 414C 4853 4D31 565F 0000 100
no_marker     01 0000 5 4C46 5341 3148 5F4D 0057 000
title_sram    C3 00A0 7 4F52 4B43 2059 4F42 4958 474E 0000 010
title_remap   05 00A0 7 455A 444C 2041 0031 0000 0000 0000 011
codes_ignored FF 00A0 7 4F52 4B43 2059 4F42 4958 474E 0000 011
title_unknown 46 00A0 7 454D 5254 494F 0044 0000 0000 0000 000
bios_tail     00 3FF8 3 AAAA BBBB CCCC 000

/* list.f */
cart_pkg.sv
bios_word_packer.sv
flash_sig_scanner.sv
cart_quirk_detect.sv
cart_loader_top.sv
cart_checker.sv
tb_cart_loader.sv

/* Makefile */
# Verilator build and run of the cartridge loader testbench

VERILATOR ?= verilator
TOP       ?= tb_cart_loader
LOG       ?= sim.log
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --assert -j 0

SRCS := $(shell cat list.f)
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes
$(BIN): $(SRCS) list.f
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f list.f

run: $(BIN) cart_testdata.txt
	./$(BIN) > $(LOG) 2>&1; cat $(LOG)
	@grep -q "NO ERRORS" $(LOG) || (echo "Simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
